// ==== Makefile ====
TOP := tb_fc_mac_ctrl

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f all.f --top-module $(TOP) -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== all.f ====
src/fc_reg_pkg.sv
src/fc_link_pkg.sv
src/fc_host_regs.sv
src/fc_credit_mgr.sv
src/fc_stat_update.sv
src/fc_stat_store.sv
src/fc_mac_ctrl.sv
sim/tb_fc_mac_ctrl.sv

// ==== sim/tb_fc_mac_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fc_mac_ctrl;

   localparam int addr_w     = fc_reg_pkg::reg_addr_w;
   localparam int data_w     = fc_reg_pkg::reg_data_w;
   localparam int credit_w   = fc_link_pkg::credit_w;
   localparam int n_stats    = fc_link_pkg::n_stats;
   localparam int busy_limit = 400;  // Covers a full drain of queued updates

   logic reg_clk, rst_n, reg_rd, reg_wr, reg_busy;
   logic [addr_w-1:0] reg_addr;
   logic [data_w-1:0] reg_data_in, reg_data_out;
   logic tx_frm_trmit, rx_r_rdy, rx_frm_rcv, rx_crc_err;
   logic [credit_w-1:0] current_credit;

   logic [31:0] rng;  // Xorshift state
   int mismatches, timeouts;
   logic track_credit;  // Per-cycle credit compare enabled
   logic burst_done;
   logic [credit_w-1:0] exp_credit, exp_cfg;  // Reference model
   logic [31:0] exp_cnt [n_stats];

   fc_mac_ctrl uut (
      .reg_clk(reg_clk), .rst_n(rst_n), .reg_rd(reg_rd), .reg_wr(reg_wr),
      .reg_addr(reg_addr), .reg_data_in(reg_data_in), .reg_data_out(reg_data_out),
      .reg_busy(reg_busy), .tx_frm_trmit(tx_frm_trmit), .rx_r_rdy(rx_r_rdy),
      .rx_frm_rcv(rx_frm_rcv), .rx_crc_err(rx_crc_err), .current_credit(current_credit));

   initial begin
      reg_clk = 1'b0;
      forever #20 reg_clk = ~reg_clk;  // 40 ns period
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   function automatic logic [31:0] next_rand();
      rng = xorshift(rng);
      return rng;
   endfunction

   // Model follows the link events as the DUT samples them
   always @(posedge reg_clk) begin
      if (rst_n) begin
         exp_cnt[fc_link_pkg::stat_tx_frm] += 32'(tx_frm_trmit);
         exp_cnt[fc_link_pkg::stat_rx_frm] += 32'(rx_frm_rcv);
         exp_cnt[fc_link_pkg::stat_rx_crc_err] += 32'(rx_crc_err);
         if (track_credit && tx_frm_trmit && !rx_r_rdy && exp_credit != '0)
            exp_credit = exp_credit - credit_w'(1);  // Floor at zero
         else if (track_credit && rx_r_rdy && !tx_frm_trmit && exp_credit < exp_cfg)
            exp_credit = exp_credit + credit_w'(1);  // Ceiling at config
      end
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("MISMATCH at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
         mismatches++;
      end
   endtask

   always @(negedge reg_clk) begin
      if (track_credit)
         check_value("current_credit", 32'(current_credit), 32'(exp_credit));
   end

   // One host access with the strobe held until busy falls
   task automatic host_access(input logic wr, input logic [addr_w-1:0] addr,
                              input logic [data_w-1:0] data, output logic [data_w-1:0] rdata);
      int t;
      reg_addr    = addr;
      reg_data_in = data;
      reg_rd      = !wr;
      reg_wr      = wr;
      t = 0;
      do begin
         @(negedge reg_clk);
         t++;
      end while (!reg_busy && t < 4);
      assert (reg_busy) else begin
         $display("Host access to 0x%02h at %0t never raised reg_busy", addr, $time);
         timeouts++;
      end
      t = 0;
      while (reg_busy && t < busy_limit) begin
         @(negedge reg_clk);
         t++;
      end
      assert (!reg_busy) else begin
         $display("Host access to 0x%02h at %0t never finished", addr, $time);
         timeouts++;
      end
      rdata  = reg_data_out;
      reg_rd = 1'b0;
      reg_wr = 1'b0;
      @(negedge reg_clk);  // Strobe low for one cycle
   endtask

   task automatic reg_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
      logic [data_w-1:0] ignored;
      host_access(1'b1, addr, data, ignored);
   endtask

   task automatic reg_read_check(input string name, input logic [addr_w-1:0] addr,
                                 input logic [data_w-1:0] exp);
      logic [data_w-1:0] got;
      host_access(1'b0, addr, '0, got);
      check_value(name, got, exp);
   endtask

   task automatic credit_reset_check();
      track_credit = 1'b0;  // DUT reloads somewhere inside the handshake
      reg_write(fc_reg_pkg::addr_cmd, 32'h1);
      exp_credit = exp_cfg;
      check_value("current_credit", 32'(current_credit), 32'(exp_cfg));
      reg_read_check("cur_credit reg", fc_reg_pkg::addr_cur_credit, 32'(exp_cfg));
      track_credit = 1'b1;
   endtask

   // Random events with each one at most once per spacing cycles
   task automatic drive_traffic(input int cycles, input int spacing,
                                input logic [7:0] rdy_mask, input logic stats);
      int cool [n_stats];
      logic [n_stats-1:0] fire;
      logic [31:0] r;
      int c;
      int i;
      for (i = 0; i < n_stats; i++)
         cool[i] = 0;
      for (c = 0; c < cycles; c++) begin
         r = next_rand();
         for (i = 0; i < n_stats; i++) begin
            fire[i] = (cool[i] == 0) && r[i] && (stats || i == 0);
            if (fire[i])
               cool[i] = spacing - 1;
            else if (cool[i] != 0)
               cool[i]--;
         end
         tx_frm_trmit = fire[fc_link_pkg::stat_tx_frm];
         rx_frm_rcv   = fire[fc_link_pkg::stat_rx_frm];
         rx_crc_err   = fire[fc_link_pkg::stat_rx_crc_err];
         rx_r_rdy     = (r[15:8] & rdy_mask) == 8'h00;
         @(negedge reg_clk);
      end
      {tx_frm_trmit, rx_r_rdy, rx_frm_rcv, rx_crc_err} = '0;
   endtask

   task automatic read_all_counters();
      int i;
      repeat (2) @(negedge reg_clk);  // Two idle cycles before the read
      for (i = 0; i < n_stats; i++)
         reg_read_check($sformatf("stat_cnt[%0d]", i),
                        addr_w'(fc_reg_pkg::addr_stat_base + i), exp_cnt[i]);
   endtask

   initial begin
      int i;
      int k;
      logic [31:0] r, lo, got;
      rng = 32'd62;
      {mismatches, timeouts} = '0;
      track_credit = 1'b0;
      burst_done   = 1'b0;
      exp_cfg    = credit_w'(fc_reg_pkg::credit_cfg_reset);
      exp_credit = exp_cfg;
      for (i = 0; i < n_stats; i++)
         exp_cnt[i] = '0;
      {rst_n, reg_rd, reg_wr, reg_addr, reg_data_in} = '0;
      {tx_frm_trmit, rx_r_rdy, rx_frm_rcv, rx_crc_err} = '0;
      repeat (3) @(posedge reg_clk);
      @(negedge reg_clk);
      rst_n = 1'b1;

      // Reset values
      reg_read_check("rev", fc_reg_pkg::addr_rev, 32'h0000_0107);
      reg_read_check("credit_cfg", fc_reg_pkg::addr_credit_cfg, 32'd8);
      reg_read_check("cur_credit reg", fc_reg_pkg::addr_cur_credit, 32'd8);
      check_value("current_credit", 32'(current_credit), 32'd8);
      read_all_counters();

      // Config readback and zero reads of command and holes
      for (i = 0; i < 8; i++) begin
         r = next_rand();
         reg_write(fc_reg_pkg::addr_credit_cfg, r);
         exp_cfg = r[credit_w-1:0];
         reg_read_check("credit_cfg", fc_reg_pkg::addr_credit_cfg, 32'(exp_cfg));
         r = next_rand();
         reg_write(addr_w'(32'h0B + r % 32'd245), r);  // 0x0B up to 0xFF
         reg_read_check("unmapped", addr_w'(32'h0B + r % 32'd245), 32'h0);
         reg_write(addr_w'(32'h04 + r[1:0]), r);  // Hole below the counters
         reg_read_check("unmapped", addr_w'(32'h04 + r[1:0]), 32'h0);
      end
      reg_write(fc_reg_pkg::addr_cmd, 32'hFFFF_FFFE);  // Bit 0 clear so no reset
      reg_read_check("cmd", fc_reg_pkg::addr_cmd, 32'h0);
      reg_write(fc_reg_pkg::addr_credit_cfg, 32'd6);
      exp_cfg = credit_w'(6);
      credit_reset_check();

      // Credit drifts down to zero and after a reload up to config
      drive_traffic(150, 4, 8'h07, 1'b0);
      credit_reset_check();
      drive_traffic(150, 4, 8'h01, 1'b0);
      repeat (40) @(negedge reg_clk);  // Let queued tx updates drain

      // Short bursts each followed by a quiet read of every counter
      for (i = 0; i < 3; i++) begin
         drive_traffic(24, 4, 8'h03, 1'b1);
         read_all_counters();
      end

      // Reads racing a longer event stream
      fork
         begin
            drive_traffic(160, 16, 8'h03, 1'b1);
            burst_done = 1'b1;
         end
         begin
            k = 0;
            while (!burst_done && k < 100) begin
               lo = exp_cnt[k % n_stats];  // Everything up to here must show
               repeat (2) @(negedge reg_clk);
               host_access(1'b0, addr_w'(fc_reg_pkg::addr_stat_base + k % n_stats), '0, got);
               assert (got >= lo && got <= exp_cnt[k % n_stats]) else begin
                  $display("MISMATCH at %0t: stat_cnt[%0d] got %0d expected %0d to %0d",
                           $time, k % n_stats, got, lo, exp_cnt[k % n_stats]);
                  mismatches++;
               end
               k++;
            end
         end
      join
      read_all_counters();

      $display("Run complete: %0d mismatches, %0d timeouts", mismatches, timeouts);
      if (mismatches == 0 && timeouts == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== src/fc_credit_mgr.sv ====
`timescale 1ns/1ps
`default_nettype none

module fc_credit_mgr #(
   parameter int credit_w = 16
) (
   input  wire                 reg_clk,
   input  wire                 rst_n,
   input  wire  [credit_w-1:0] credit_cfg,  // Upper saturation bound
   input  wire                 tx_frm_trmit,  // Frame sent, spends one credit
   input  wire                 rx_r_rdy,  // R_RDY seen, returns one credit
   input  wire                 credit_reset_req,
   output logic                credit_reset_ack,
   output logic [credit_w-1:0] current_credit
);

   always_ff @(posedge reg_clk) begin
      if (!rst_n) begin
         current_credit   <= credit_w'(fc_reg_pkg::credit_cfg_reset);
         credit_reset_ack <= 1'b0;
      end else begin
         if (credit_reset_req && !credit_reset_ack) begin
            current_credit   <= credit_cfg;  // Reload from configuration
            credit_reset_ack <= 1'b1;
         end else if (current_credit > credit_cfg) begin
            current_credit <= credit_cfg;  // Config was lowered under us
         end else if (tx_frm_trmit && !rx_r_rdy) begin
            if (current_credit != '0)
               current_credit <= current_credit - 1'b1;  // Floor at zero
         end else if (rx_r_rdy && !tx_frm_trmit) begin
            if (current_credit < credit_cfg)
               current_credit <= current_credit + 1'b1;  // Cap at config
         end
         // Both events together cancel out

         if (credit_reset_ack && !credit_reset_req)
            credit_reset_ack <= 1'b0;  // Close the four-phase cycle
      end
   end

   // Credit stays within config, one cycle of slack after config drops
   a_credit_cap: assert property (@(posedge reg_clk) disable iff (!rst_n)
      (current_credit <= credit_cfg) || ($past(credit_cfg) > credit_cfg))
      else $error("current_credit above credit_cfg");

endmodule

`default_nettype wire

// ==== src/fc_host_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module fc_host_regs (
   input  wire                                reg_clk,
   input  wire                                rst_n,
   input  wire                                reg_rd,  // Read strobe
   input  wire                                reg_wr,  // Write strobe
   input  wire  [fc_reg_pkg::reg_addr_w-1:0]  reg_addr,
   input  wire  [fc_reg_pkg::reg_data_w-1:0]  reg_data_in,
   output logic [fc_reg_pkg::reg_data_w-1:0]  reg_data_out,
   output logic                               reg_busy,
   output logic [fc_link_pkg::credit_w-1:0]   credit_cfg,  // Configured credit
   input  wire  [fc_link_pkg::credit_w-1:0]   current_credit,
   output logic                               credit_reset_req,
   input  wire                                credit_reset_ack,
   output logic                               rd_req,  // Counter read request
   output logic [fc_link_pkg::stat_idx_w-1:0] rd_idx,
   input  wire                                rd_ack,
   input  wire  [fc_reg_pkg::reg_data_w-1:0]  rd_data
);

   localparam int data_w = fc_reg_pkg::reg_data_w;
   localparam int addr_w = fc_reg_pkg::reg_addr_w;
   localparam int idx_w  = fc_link_pkg::stat_idx_w;

   typedef enum logic [2:0] {
      st_idle, st_decode, st_cmd, st_cmd_rel, st_rd, st_rd_rel, st_done
   } state_t;

   state_t state;
   logic [addr_w-1:0] stat_off;  // Address relative to first counter
   logic is_stat;  // Address hits the counter window
   logic [data_w-1:0] rd_mux;  // Direct register read value

   assign stat_off = reg_addr - fc_reg_pkg::addr_stat_base;  // Wraps high below base
   assign is_stat  = stat_off < addr_w'(fc_link_pkg::n_stats);

   always_comb begin
      case (reg_addr)
         fc_reg_pkg::addr_rev:        rd_mux = fc_reg_pkg::rev_value;
         fc_reg_pkg::addr_credit_cfg: rd_mux = data_w'(credit_cfg);
         fc_reg_pkg::addr_cur_credit: rd_mux = data_w'(current_credit);
         default:                     rd_mux = '0;  // Command and holes read zero
      endcase
   end

   always_ff @(posedge reg_clk) begin
      if (!rst_n) begin
         state            <= st_idle;
         reg_busy         <= 1'b0;
         credit_reset_req <= 1'b0;
         rd_req           <= 1'b0;
         credit_cfg       <= fc_link_pkg::credit_w'(fc_reg_pkg::credit_cfg_reset);
      end else begin
         case (state)
            st_idle: if (reg_rd || reg_wr) begin
               state    <= st_decode;  // Busy shows the cycle after the strobe
               reg_busy <= 1'b1;
            end
            st_decode: begin
               if (reg_wr && reg_addr == fc_reg_pkg::addr_cmd && reg_data_in[0]) begin
                  credit_reset_req <= 1'b1;  // Hand off to credit manager
                  state            <= st_cmd;
               end else if (reg_rd && is_stat) begin
                  rd_req <= 1'b1;  // Counter lives in the store
                  rd_idx <= stat_off[idx_w-1:0];
                  state  <= st_rd;
               end else begin
                  if (reg_wr && reg_addr == fc_reg_pkg::addr_credit_cfg)
                     credit_cfg <= reg_data_in[fc_link_pkg::credit_w-1:0];
                  if (reg_rd)
                     reg_data_out <= rd_mux;
                  reg_busy <= 1'b0;  // Fixed two-cycle access
                  state    <= st_done;
               end
            end
            st_cmd: if (credit_reset_ack) begin
               credit_reset_req <= 1'b0;
               state            <= st_cmd_rel;
            end
            st_cmd_rel: if (!credit_reset_ack) begin
               reg_busy <= 1'b0;  // Handshake fully closed
               state    <= st_done;
            end
            st_rd: if (rd_ack) begin
               reg_data_out <= rd_data;  // Captured while ack holds it
               rd_req       <= 1'b0;
               state        <= st_rd_rel;
            end
            st_rd_rel: if (!rd_ack) begin
               reg_busy <= 1'b0;
               state    <= st_done;
            end
            st_done: if (!reg_rd && !reg_wr)
               state <= st_idle;  // Wait for host to drop strobe
            default: state <= st_idle;
         endcase
      end
   end

   // Request may only be withdrawn once the credit manager answered
   a_req_held: assert property (@(posedge reg_clk) disable iff (!rst_n)
      $fell(credit_reset_req) |-> $past(credit_reset_ack))
      else $error("credit_reset_req dropped before ack");

endmodule

`default_nettype wire

// ==== src/fc_link_pkg.sv ====
`default_nettype none

package fc_link_pkg;

   // Buffer-to-buffer credit
   localparam int credit_w = 16;  // Credit counter width

   // Statistics counters
   localparam int stat_cnt_w = 32;  // One counter word
   localparam int n_stats    = 3;  // Counters in the store
   localparam int stat_idx_w = 2;  // Counter select width

   // Counter indices
   localparam int stat_tx_frm     = 0;  // Frames transmitted
   localparam int stat_rx_frm     = 1;  // Frames received
   localparam int stat_rx_crc_err = 2;  // Received frames with bad CRC

   // Event back-pressure
   localparam int pend_w = 3;  // Up to 7 pulses queued per counter

endpackage

`default_nettype wire

// ==== src/fc_mac_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module fc_mac_ctrl #(
   parameter int n_stats    = fc_link_pkg::n_stats,
   parameter int pend_w     = fc_link_pkg::pend_w,
   parameter int stat_cnt_w = fc_link_pkg::stat_cnt_w,
   parameter int credit_w   = fc_link_pkg::credit_w
) (
   input  wire                               reg_clk,  // Register clock, whole block
   input  wire                               rst_n,
   input  wire                               reg_rd,
   input  wire                               reg_wr,
   input  wire  [fc_reg_pkg::reg_addr_w-1:0] reg_addr,
   input  wire  [fc_reg_pkg::reg_data_w-1:0] reg_data_in,
   output logic [fc_reg_pkg::reg_data_w-1:0] reg_data_out,
   output logic                              reg_busy,
   input  wire                               tx_frm_trmit,  // Link events, already in reg_clk
   input  wire                               rx_r_rdy,
   input  wire                               rx_frm_rcv,
   input  wire                               rx_crc_err,
   output logic [credit_w-1:0]               current_credit
);

   logic [credit_w-1:0] credit_cfg;
   logic credit_reset_req, credit_reset_ack;  // Credit reset handshake
   logic upd_req, upd_ack, stat_busy;  // Update port
   logic [fc_link_pkg::stat_idx_w-1:0] upd_idx;
   logic rd_req, rd_ack;  // Host read port
   logic [fc_link_pkg::stat_idx_w-1:0] rd_idx;
   logic [stat_cnt_w-1:0] rd_data;

   fc_host_regs u_regs (
      .reg_clk(reg_clk), .rst_n(rst_n), .reg_rd(reg_rd), .reg_wr(reg_wr),
      .reg_addr(reg_addr), .reg_data_in(reg_data_in), .reg_data_out(reg_data_out),
      .reg_busy(reg_busy), .credit_cfg(credit_cfg), .current_credit(current_credit),
      .credit_reset_req(credit_reset_req), .credit_reset_ack(credit_reset_ack),
      .rd_req(rd_req), .rd_idx(rd_idx), .rd_ack(rd_ack), .rd_data(rd_data));

   fc_credit_mgr #(.credit_w(credit_w)) u_credit (
      .reg_clk(reg_clk), .rst_n(rst_n), .credit_cfg(credit_cfg),
      .tx_frm_trmit(tx_frm_trmit), .rx_r_rdy(rx_r_rdy),
      .credit_reset_req(credit_reset_req), .credit_reset_ack(credit_reset_ack),
      .current_credit(current_credit));

   fc_stat_update #(.n_stats(n_stats), .pend_w(pend_w)) u_upd (
      .reg_clk(reg_clk), .rst_n(rst_n), .tx_frm_trmit(tx_frm_trmit),
      .rx_frm_rcv(rx_frm_rcv), .rx_crc_err(rx_crc_err), .upd_req(upd_req),
      .upd_idx(upd_idx), .upd_ack(upd_ack), .stat_busy(stat_busy));

   fc_stat_store #(.n_stats(n_stats), .stat_cnt_w(stat_cnt_w)) u_store (
      .reg_clk(reg_clk), .rst_n(rst_n), .upd_req(upd_req), .upd_idx(upd_idx),
      .upd_ack(upd_ack), .stat_busy(stat_busy), .rd_req(rd_req), .rd_idx(rd_idx),
      .rd_ack(rd_ack), .rd_data(rd_data));

endmodule

`default_nettype wire

// ==== src/fc_reg_pkg.sv ====
`default_nettype none

package fc_reg_pkg;

   // Host bus geometry
   localparam int reg_addr_w = 8;  // Word address, as on the FC core host port
   localparam int reg_data_w = 32;  // Host data width

   // Register map
   localparam logic [reg_addr_w-1:0] addr_rev        = 8'h00;  // Revision, read only
   localparam logic [reg_addr_w-1:0] addr_cmd        = 8'h01;  // Bit 0 starts credit reset
   localparam logic [reg_addr_w-1:0] addr_credit_cfg = 8'h02;  // Configured BB credit
   localparam logic [reg_addr_w-1:0] addr_cur_credit = 8'h03;  // Live credit, read only
   localparam logic [reg_addr_w-1:0] addr_stat_base  = 8'h08;  // First statistics counter

   // Reset and constant values
   localparam int credit_cfg_reset = 8;  // Credit after reset
   localparam logic [reg_data_w-1:0] rev_value = 32'h0000_0107;  // Core revision

endpackage

`default_nettype wire

// ==== src/fc_stat_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module fc_stat_store #(
   parameter int n_stats    = 3,
   parameter int stat_cnt_w = 32
) (
   input  wire                                reg_clk,
   input  wire                                rst_n,
   input  wire                                upd_req,  // Increment port
   input  wire  [fc_link_pkg::stat_idx_w-1:0] upd_idx,
   output logic                               upd_ack,
   input  wire                                stat_busy,  // Updater still has work
   input  wire                                rd_req,  // Host read port
   input  wire  [fc_link_pkg::stat_idx_w-1:0] rd_idx,
   output logic                               rd_ack,
   output logic [stat_cnt_w-1:0]              rd_data  // Valid while rd_ack is high
);

   logic [stat_cnt_w-1:0] cnt_mem [n_stats];  // Counter memory
   logic port_idle;  // No handshake open on either port
   logic upd_grant;
   logic rd_grant;

   assign port_idle = !upd_ack && !rd_ack;
   assign upd_grant = port_idle && upd_req;  // Update always wins
   assign rd_grant  = port_idle && !upd_req && rd_req && !stat_busy;  // Only when drained

   always_ff @(posedge reg_clk) begin
      if (!rst_n) begin
         for (int i = 0; i < n_stats; i++)
            cnt_mem[i] <= '0;  // Counters start from zero
         upd_ack <= 1'b0;
         rd_ack  <= 1'b0;
      end else begin
         if (upd_grant) begin
            cnt_mem[upd_idx] <= cnt_mem[upd_idx] + stat_cnt_w'(1);  // Wraps at top
            upd_ack          <= 1'b1;
         end else if (rd_grant) begin
            rd_data <= cnt_mem[rd_idx];
            rd_ack  <= 1'b1;
         end

         if (upd_ack && !upd_req)
            upd_ack <= 1'b0;
         if (rd_ack && !rd_req)
            rd_ack <= 1'b0;
      end
   end

   // One port owns the memory at a time
   a_one_owner: assert property (@(posedge reg_clk) disable iff (!rst_n)
      !(upd_ack && rd_ack))
      else $error("update and read acknowledged together");

endmodule

`default_nettype wire

// ==== src/fc_stat_update.sv ====
`timescale 1ns/1ps
`default_nettype none

module fc_stat_update #(
   parameter int n_stats = 3,
   parameter int pend_w  = 3
) (
   input  wire                                reg_clk,
   input  wire                                rst_n,
   input  wire                                tx_frm_trmit,
   input  wire                                rx_frm_rcv,
   input  wire                                rx_crc_err,
   output logic                               upd_req,
   output logic [fc_link_pkg::stat_idx_w-1:0] upd_idx,  // Held while upd_req is high
   input  wire                                upd_ack,
   output logic                               stat_busy  // Counts not yet in the store
);

   localparam int idx_w = fc_link_pkg::stat_idx_w;
   localparam logic [pend_w-1:0] pend_max = '1;

   logic [n_stats-1:0] ev;  // Event pulses by counter index
   logic [pend_w-1:0] pend [n_stats];  // Queued pulses per counter
   logic [n_stats-1:0] pend_nz;
   logic [n_stats-1:0] retire;  // Handshake done for this counter
   logic [n_stats-1:0] lost;  // Pulse dropped on a full queue
   logic [idx_w-1:0] sel_idx;  // Lowest counter with work
   logic upd_done;

   assign ev[fc_link_pkg::stat_tx_frm]     = tx_frm_trmit;
   assign ev[fc_link_pkg::stat_rx_frm]     = rx_frm_rcv;
   assign ev[fc_link_pkg::stat_rx_crc_err] = rx_crc_err;

   assign upd_done  = upd_req && upd_ack;  // Store has written the increment
   assign stat_busy = (|pend_nz) || upd_req;

   always_comb begin
      sel_idx = '0;
      for (int i = n_stats - 1; i >= 0; i--) begin  // Downward so lowest wins
         pend_nz[i] = pend[i] != '0;
         retire[i]  = upd_done && (upd_idx == idx_w'(i));
         lost[i]    = ev[i] && (pend[i] == pend_max) && !retire[i];
         if (pend_nz[i])
            sel_idx = idx_w'(i);
      end
   end

   always_ff @(posedge reg_clk) begin
      if (!rst_n) begin
         for (int i = 0; i < n_stats; i++)
            pend[i] <= '0;
         upd_req <= 1'b0;
      end else begin
         for (int i = 0; i < n_stats; i++)
            pend[i] <= pend[i] + pend_w'(ev[i] && !lost[i]) - pend_w'(retire[i]);
         if (upd_done) begin
            upd_req <= 1'b0;
         end else if (!upd_req && !upd_ack && (|pend_nz)) begin
            upd_req <= 1'b1;  // New round once the store dropped ack
            upd_idx <= sel_idx;
         end
      end
   end

   // Event rate beyond the queue depth loses counts
   a_no_overflow: assert property (@(posedge reg_clk) disable iff (!rst_n)
      lost == '0)
      else $error("statistics pending count overflow");

endmodule

`default_nettype wire
